//--- source/icache_bus_pkg.sv
package icache_bus_pkg;

	// one address or instruction word
	typedef logic [31:0] word_t;

	// line fill request, addr is line aligned
	typedef struct packed {
		logic  valid;
		word_t addr;
	} mem_req_t;

	// one beat of the line coming back
	typedef struct packed {
		logic  valid;
		logic  last;  // final beat of the line
		word_t data;
	} mem_resp_t;

endpackage

//--- source/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

	import icache_bus_pkg::*;

	typedef struct packed {
		logic  valid;
		word_t addr;  // virtual
	} fetch_req_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} fetch_rsp_t;

	typedef enum logic [1:0] {
		op_none,
		op_index_inv,
		op_index_store_tag,
		op_hit_inv
	} cache_op_t;

	typedef struct packed {
		cache_op_t op;
		word_t     addr;
		word_t     tag;  // low TAG_WIDTH bits used
	} cache_op_req_t;

	typedef enum logic [1:0] {
		st_invalidate,
		st_lookup,
		st_refill,
		st_maint
	} icache_state_t;

endpackage

//--- source/icache_tag_array.sv
`timescale 1ns/100ps

module icache_tag_array
	import icache_bus_pkg::*;
#(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 16 * 1024,
	parameter int TAG_WIDTH = 20
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic [$clog2(CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC))-1:0] i_rindex,
	input  word_t i_pa,
	input  logic [SET_ASSOC-1:0] i_wen,
	input  logic [$clog2(CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC))-1:0] i_windex,
	input  logic i_wvalid,
	input  logic [TAG_WIDTH-1:0] i_wtag,
	output logic o_hit,
	output logic [$clog2(SET_ASSOC)-1:0] o_hit_way,
	output logic [SET_ASSOC-1:0][TAG_WIDTH-1:0] o_way_tag
);

	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC);
	localparam int WAY_W = $clog2(SET_ASSOC);

	typedef logic [TAG_WIDTH-1:0] tag_t;

	tag_t pa_tag;
	logic [SET_ASSOC-1:0] way_hit;

	assign pa_tag = i_pa[31 -: TAG_WIDTH];

	for (genvar w = 0; w < SET_ASSOC; w++) begin : g_way
		tag_t tag_mem [SETS];
		logic [SETS-1:0] valid_mem;
		tag_t rd_tag;
		logic rd_valid;

		always_ff @(posedge i_clk) begin
			if (i_wen[w]) begin
				tag_mem[i_windex] <= i_wtag;
				valid_mem[i_windex] <= i_wvalid;
			end
			rd_tag <= tag_mem[i_rindex];
		end

		always_ff @(posedge i_clk) begin
			if (i_rst)
				rd_valid <= 1'b0;
			else
				rd_valid <= valid_mem[i_rindex];
		end

		assign o_way_tag[w] = rd_tag;
		assign way_hit[w] = rd_valid && (rd_tag == pa_tag);  // stage two compare
	end

	// at most one way matches, so or-ing the indexes encodes it
	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < SET_ASSOC; w++) begin
			if (way_hit[w])
				o_hit_way = o_hit_way | WAY_W'(w);
		end
	end

	assign o_hit = |way_hit;

endmodule

//--- source/icache_data_array.sv
`timescale 1ns/100ps

module icache_data_array
	import icache_bus_pkg::*;
#(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 16 * 1024
) (
	input  logic i_clk,
	input  logic [$clog2(CACHE_SIZE / (SET_ASSOC * 4))-1:0] i_raddr,
	input  logic [$clog2(SET_ASSOC)-1:0] i_way_sel,  // read and fill way
	input  logic i_wen,
	input  logic [$clog2(CACHE_SIZE / (SET_ASSOC * 4))-1:0] i_waddr,
	input  word_t i_wdata,
	output word_t o_rdata
);

	localparam int DEPTH = CACHE_SIZE / (SET_ASSOC * 4);  // words per way
	localparam int WAY_W = $clog2(SET_ASSOC);

	word_t [SET_ASSOC-1:0] rd_words;

	for (genvar w = 0; w < SET_ASSOC; w++) begin : g_way
		word_t mem [DEPTH];
		word_t rd_word;

		always_ff @(posedge i_clk) begin
			if (i_wen && i_way_sel == WAY_W'(w))
				mem[i_waddr] <= i_wdata;
			rd_word <= mem[i_raddr];
		end

		assign rd_words[w] = rd_word;
	end

	assign o_rdata = rd_words[i_way_sel];

	// words per line only fixes the address split, check it stays sane
	initial begin
		if (WORD_PER_LINE < 2)
			$error("icache_data_array needs at least two words per line");
	end

endmodule

//--- source/icache_plru.sv
`timescale 1ns/100ps

module icache_plru #(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 16 * 1024
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic [$clog2(CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC))-1:0] i_index,
	input  logic i_touch,
	input  logic [$clog2(SET_ASSOC)-1:0] i_touch_way,
	output logic [$clog2(SET_ASSOC)-1:0] o_victim_way
);

	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC);
	localparam int TREE_W = SET_ASSOC - 1;

	typedef logic [TREE_W-1:0] tree_t;

	tree_t [SETS-1:0] tree_q;
	tree_t cur;
	tree_t nxt;

	assign cur = tree_q[i_index];

	if (SET_ASSOC == 4) begin : g_four
		// bit 0 is the root, bit 1 covers ways 0/1, bit 2 ways 2/3
		always_comb begin
			o_victim_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
			nxt = cur;
			nxt[0] = ~i_touch_way[1];  // point at the other half
			if (i_touch_way[1])
				nxt[2] = ~i_touch_way[0];
			else
				nxt[1] = ~i_touch_way[0];
		end
	end else begin : g_two
		assign o_victim_way = cur;
		assign nxt = ~i_touch_way;  // way not touched last
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			tree_q <= '0;
		else if (i_touch)
			tree_q[i_index] <= nxt;
	end

endmodule

//--- source/icache_refill.sv
`timescale 1ns/100ps

module icache_refill
	import icache_bus_pkg::*;
#(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 16 * 1024
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	input  word_t i_line_pa,
	input  logic [$clog2(WORD_PER_LINE)-1:0] i_crit_offset,
	input  logic i_mem_req_ready,
	input  mem_resp_t i_mem_resp,
	output mem_req_t o_mem_req,
	output logic o_fill_wen,
	output logic [$clog2(CACHE_SIZE / (SET_ASSOC * 4))-1:0] o_fill_addr,
	output word_t o_fill_data,
	output logic o_crit_valid,
	output logic o_fill_done
);

	localparam int LINE_OFF = $clog2(WORD_PER_LINE * 4);
	localparam int WORD_BITS = $clog2(WORD_PER_LINE);
	localparam int INDEX_W = $clog2(CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC));

	logic busy_q;
	logic req_valid_q;
	word_t req_addr_q;
	logic [WORD_BITS-1:0] beat_q;
	logic [WORD_BITS-1:0] crit_q;
	logic [INDEX_W-1:0] fill_index_q;
	logic beat;

	// beats only count once the request has gone out
	assign beat = busy_q && !req_valid_q && i_mem_resp.valid;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			busy_q <= 1'b0;
			req_valid_q <= 1'b0;
			beat_q <= '0;
		end else if (i_start) begin
			busy_q <= 1'b1;
			req_valid_q <= 1'b1;
			beat_q <= '0;
		end else begin
			if (req_valid_q && i_mem_req_ready)
				req_valid_q <= 1'b0;  // accepted
			if (beat) begin
				beat_q <= beat_q + 1'b1;
				if (i_mem_resp.last)
					busy_q <= 1'b0;
			end
		end
	end

	// index bits sit inside the page offset, so pa and va agree on them
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			req_addr_q <= i_line_pa;
			crit_q <= i_crit_offset;
			fill_index_q <= i_line_pa[LINE_OFF +: INDEX_W];
		end
	end

	assign o_mem_req.valid = req_valid_q;
	assign o_mem_req.addr = req_addr_q;

	assign o_fill_wen = beat;
	assign o_fill_addr = {fill_index_q, beat_q};
	assign o_fill_data = i_mem_resp.data;
	assign o_crit_valid = beat && (beat_q == crit_q);  // requested word
	assign o_fill_done = beat && i_mem_resp.last;

endmodule

//--- source/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl
	import icache_bus_pkg::*;
	import icache_ctrl_pkg::*;
#(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 16 * 1024,
	parameter int TAG_WIDTH = 20
) (
	input  logic i_clk,
	input  logic i_rst,
	input  fetch_req_t i_fetch,
	input  word_t i_pa,
	input  cache_op_req_t i_cop,
	input  logic i_hit,
	input  logic [$clog2(SET_ASSOC)-1:0] i_hit_way,
	input  logic [SET_ASSOC-1:0][TAG_WIDTH-1:0] i_way_tag,
	input  word_t i_rdata,
	input  logic [$clog2(SET_ASSOC)-1:0] i_victim_way,
	input  logic i_crit_valid,
	input  word_t i_fill_data,
	input  logic i_fill_done,
	output fetch_rsp_t o_fetch_rsp,
	output logic o_stall,
	output logic o_ready,
	output logic [$clog2(CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC))-1:0] o_rindex,
	output logic [$clog2(CACHE_SIZE / (SET_ASSOC * 4))-1:0] o_raddr,
	output logic [$clog2(SET_ASSOC)-1:0] o_way_sel,
	output logic [SET_ASSOC-1:0] o_tag_wen,
	output logic [$clog2(CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC))-1:0] o_tag_windex,
	output logic o_tag_wvalid,
	output logic [TAG_WIDTH-1:0] o_tag_wtag,
	output logic [$clog2(CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC))-1:0] o_lru_index,
	output logic o_lru_touch,
	output logic [$clog2(SET_ASSOC)-1:0] o_lru_touch_way,
	output logic o_fill_start,
	output word_t o_line_pa,
	output logic [$clog2(WORD_PER_LINE)-1:0] o_crit_offset
);

	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC);
	localparam int LINE_OFF = $clog2(WORD_PER_LINE * 4);
	localparam int WORD_BITS = $clog2(WORD_PER_LINE);
	localparam int INDEX_W = $clog2(SETS);
	localparam int WAY_W = $clog2(SET_ASSOC);

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [WAY_W-1:0] way_t;

	icache_state_t state_q, state_d;
	index_t sweep_q;
	logic s2_valid_q;
	index_t s2_index_q;
	index_t fetch_index;
	index_t miss_index_q;
	tag_t miss_tag_q;
	way_t miss_way_q;
	cache_op_req_t cop_q;
	index_t cop_index;
	way_t cop_way;
	tag_t cop_tag;
	logic miss;
	logic cop_go;

	assign fetch_index = i_fetch.addr[LINE_OFF +: INDEX_W];
	assign cop_index = cop_q.addr[LINE_OFF +: INDEX_W];
	assign cop_way = cop_q.addr[LINE_OFF + INDEX_W +: WAY_W];  // bits above the index
	assign cop_tag = cop_q.addr[31 -: TAG_WIDTH];

	assign miss = state_q == st_lookup && s2_valid_q && !i_hit;
	assign o_ready = state_q == st_lookup && !s2_valid_q;
	assign cop_go = o_ready && i_cop.op != op_none;  // takes the read port this cycle
	assign o_stall = state_q != st_lookup || miss;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_invalidate: if (sweep_q == index_t'(SETS - 1)) state_d = st_lookup;
			st_lookup: begin
				if (miss)
					state_d = st_refill;
				else if (cop_go)
					state_d = st_maint;
			end
			st_refill: if (i_fill_done) state_d = st_lookup;
			st_maint: state_d = st_lookup;
			default: state_d = st_invalidate;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= st_invalidate;
			sweep_q <= '0;
			s2_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == st_invalidate)
				sweep_q <= sweep_q + 1'b1;
			s2_valid_q <= state_q == st_lookup && !o_stall && !cop_go && i_fetch.valid;
		end
	end

	always_ff @(posedge i_clk) begin
		s2_index_q <= fetch_index;
		if (miss) begin
			miss_index_q <= s2_index_q;
			miss_tag_q <= i_pa[31 -: TAG_WIDTH];
			miss_way_q <= i_victim_way;
		end
		if (cop_go)
			cop_q <= i_cop;
	end

	// hit word from the arrays, or the critical beat during refill
	assign o_fetch_rsp.valid = (state_q == st_lookup && s2_valid_q && i_hit) ||
		(state_q == st_refill && i_crit_valid);
	assign o_fetch_rsp.data = (state_q == st_refill) ? i_fill_data : i_rdata;

	assign o_rindex = cop_go ? cop_index_in(i_cop.addr) : fetch_index;
	assign o_raddr = {fetch_index, i_fetch.addr[2 +: WORD_BITS]};
	assign o_way_sel = (state_q == st_refill) ? miss_way_q : i_hit_way;

	assign o_lru_index = s2_index_q;
	assign o_lru_touch = state_q == st_lookup && s2_valid_q;
	assign o_lru_touch_way = i_hit ? i_hit_way : i_victim_way;  // victim becomes newest

	assign o_fill_start = miss;
	assign o_line_pa = {i_pa[31:LINE_OFF], {LINE_OFF{1'b0}}};
	assign o_crit_offset = i_pa[2 +: WORD_BITS];

	function automatic index_t cop_index_in(input word_t addr);
		return addr[LINE_OFF +: INDEX_W];
	endfunction

	always_comb begin
		o_tag_wen = '0;
		o_tag_windex = sweep_q;
		o_tag_wvalid = 1'b0;
		o_tag_wtag = '0;
		case (state_q)
			st_invalidate: o_tag_wen = '1;  // sweep clears all ways
			st_refill: begin
				o_tag_windex = miss_index_q;
				o_tag_wvalid = 1'b1;
				o_tag_wtag = miss_tag_q;
				if (i_fill_done)
					o_tag_wen[miss_way_q] = 1'b1;
			end
			st_maint: begin
				o_tag_windex = cop_index;
				o_tag_wtag = cop_q.tag[TAG_WIDTH-1:0];
				case (cop_q.op)
					op_index_inv: o_tag_wen[cop_way] = 1'b1;
					op_index_store_tag: begin
						o_tag_wen[cop_way] = 1'b1;
						o_tag_wvalid = 1'b1;
					end
					op_hit_inv: begin
						for (int w = 0; w < SET_ASSOC; w++)
							o_tag_wen[w] = i_way_tag[w] == cop_tag;
					end
					default: o_tag_wen = '0;
				endcase
			end
			default: o_tag_wen = '0;
		endcase
	end

endmodule

//--- source/icache_top.sv
`timescale 1ns/100ps

module icache_top
	import icache_bus_pkg::*;
	import icache_ctrl_pkg::*;
#(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 16 * 1024,
	parameter int TAG_WIDTH = 20
) (
	input  logic i_clk,
	input  logic i_rst,
	input  fetch_req_t i_fetch,
	input  word_t i_pa,  // one cycle after i_fetch
	output fetch_rsp_t o_fetch_rsp,
	output logic o_stall,
	output logic o_ready,
	input  cache_op_req_t i_cop,
	output mem_req_t o_mem_req,
	input  logic i_mem_req_ready,
	input  mem_resp_t i_mem_resp
);

	localparam int INDEX_W = $clog2(CACHE_SIZE / (WORD_PER_LINE * 4 * SET_ASSOC));
	localparam int ADDR_W = $clog2(CACHE_SIZE / (SET_ASSOC * 4));
	localparam int WORD_BITS = $clog2(WORD_PER_LINE);
	localparam int WAY_W = $clog2(SET_ASSOC);

	logic [INDEX_W-1:0] rindex, tag_windex, lru_index;
	logic [ADDR_W-1:0] raddr, fill_addr;
	logic hit, tag_wvalid, lru_touch, fill_start, fill_wen, crit_valid, fill_done;
	logic [WAY_W-1:0] hit_way, way_sel, lru_touch_way, victim_way;
	logic [SET_ASSOC-1:0][TAG_WIDTH-1:0] way_tag;
	logic [SET_ASSOC-1:0] tag_wen;
	logic [TAG_WIDTH-1:0] tag_wtag;
	logic [WORD_BITS-1:0] crit_offset;
	word_t rdata, line_pa, fill_data;

	icache_ctrl #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE),
		.TAG_WIDTH(TAG_WIDTH)
	) u_ctrl (
		.i_clk, .i_rst, .i_fetch, .i_pa, .i_cop,
		.i_hit(hit), .i_hit_way(hit_way), .i_way_tag(way_tag), .i_rdata(rdata),
		.i_victim_way(victim_way), .i_crit_valid(crit_valid),
		.i_fill_data(fill_data), .i_fill_done(fill_done),
		.o_fetch_rsp, .o_stall, .o_ready,
		.o_rindex(rindex), .o_raddr(raddr), .o_way_sel(way_sel),
		.o_tag_wen(tag_wen), .o_tag_windex(tag_windex),
		.o_tag_wvalid(tag_wvalid), .o_tag_wtag(tag_wtag),
		.o_lru_index(lru_index), .o_lru_touch(lru_touch), .o_lru_touch_way(lru_touch_way),
		.o_fill_start(fill_start), .o_line_pa(line_pa), .o_crit_offset(crit_offset)
	);

	icache_tag_array #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE),
		.TAG_WIDTH(TAG_WIDTH)
	) u_tag_array (
		.i_clk, .i_rst, .i_rindex(rindex), .i_pa,
		.i_wen(tag_wen), .i_windex(tag_windex), .i_wvalid(tag_wvalid), .i_wtag(tag_wtag),
		.o_hit(hit), .o_hit_way(hit_way), .o_way_tag(way_tag)
	);

	icache_data_array #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE)
	) u_data_array (
		.i_clk, .i_raddr(raddr), .i_way_sel(way_sel),
		.i_wen(fill_wen), .i_waddr(fill_addr), .i_wdata(fill_data),
		.o_rdata(rdata)
	);

	icache_plru #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE)
	) u_plru (
		.i_clk, .i_rst, .i_index(lru_index), .i_touch(lru_touch),
		.i_touch_way(lru_touch_way), .o_victim_way(victim_way)
	);

	icache_refill #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE)
	) u_refill (
		.i_clk, .i_rst, .i_start(fill_start), .i_line_pa(line_pa),
		.i_crit_offset(crit_offset), .i_mem_req_ready, .i_mem_resp,
		.o_mem_req, .o_fill_wen(fill_wen), .o_fill_addr(fill_addr),
		.o_fill_data(fill_data), .o_crit_valid(crit_valid), .o_fill_done(fill_done)
	);

endmodule

//--- bench/icache_chk.sv
`timescale 1ns/100ps

module icache_chk
	import icache_bus_pkg::*;
	import icache_ctrl_pkg::*;
(
	input  logic i_clk,
	input  logic i_rst,
	input  mem_req_t i_mem_req,
	input  logic i_mem_req_ready,
	input  mem_resp_t i_mem_resp,
	input  fetch_rsp_t i_fetch_rsp
);

	int n_errors = 0;
	logic outstanding;  // accepted request still waiting for its last beat

	always_ff @(posedge i_clk) begin
		if (i_rst)
			outstanding <= 1'b0;
		else if (i_mem_req.valid && i_mem_req_ready)
			outstanding <= 1'b1;
		else if (i_mem_resp.valid && i_mem_resp.last)
			outstanding <= 1'b0;
	end

	a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_req.valid && !i_mem_req_ready |=> i_mem_req.valid && $stable(i_mem_req.addr))
	else begin
		n_errors++;
		$error("memory request changed before it was accepted");
	end

	a_one_outstanding: assert property (@(posedge i_clk) disable iff (i_rst)
		outstanding |-> !i_mem_req.valid)
	else begin
		n_errors++;
		$error("new memory request before the last beat");
	end

	a_no_rsp_in_reset: assert property (@(posedge i_clk)
		i_rst && $past(i_rst) |-> !i_fetch_rsp.valid)
	else begin
		n_errors++;
		$error("fetch response valid during reset");
	end

endmodule

//--- bench/icache_clk_gen.sv
`timescale 1ns/100ps

module icache_clk_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic o_clk,
	output logic o_rst
);

	initial o_clk = 1'b0;
	always #(PERIOD / 2) o_clk = ~o_clk;

	initial begin
		o_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#10 o_rst = 1'b0;  // released just after the edge like other inputs
	end

endmodule

//--- bench/icache_tb.sv
`timescale 1ns/100ps

module icache_tb
	import icache_bus_pkg::*;
	import icache_ctrl_pkg::*;
;

	localparam int WPL = 8;
	localparam int ASSOC = 4;
	localparam int CSIZE = 16 * 1024;
	localparam int TAGW = 20;
	localparam int SETS = CSIZE / (WPL * 4 * ASSOC);
	localparam int MAX_LINES = 64;

	logic clk;
	logic rst;
	fetch_req_t fetch;
	word_t pa;
	fetch_rsp_t fetch_rsp;
	logic stall;
	logic ready;
	cache_op_req_t cop;
	mem_req_t mem_req;
	logic mem_req_ready;
	mem_resp_t mem_resp;

	// cmd [39:36], address [35:4], expected miss [3:0]
	logic [39:0] stim [MAX_LINES];
	int n_lines;
	int cycles = 0;
	int cycle_limit = 1000000;

	// memory model bookkeeping
	int req_count = 0;
	int beats_sent = 0;
	word_t last_req_addr = '0;

	icache_clk_gen #(.PERIOD(100), .RESET_CYCLES(8)) u_clk_gen (
		.o_clk(clk),
		.o_rst(rst)
	);

	icache_top #(
		.WORD_PER_LINE(WPL),
		.SET_ASSOC(ASSOC),
		.CACHE_SIZE(CSIZE),
		.TAG_WIDTH(TAGW)
	) DUT (
		.i_clk(clk), .i_rst(rst), .i_fetch(fetch), .i_pa(pa),
		.o_fetch_rsp(fetch_rsp), .o_stall(stall), .o_ready(ready), .i_cop(cop),
		.o_mem_req(mem_req), .i_mem_req_ready(mem_req_ready), .i_mem_resp(mem_resp)
	);

	bind icache_top icache_chk u_chk (
		.i_clk(i_clk), .i_rst(i_rst), .i_mem_req(o_mem_req),
		.i_mem_req_ready(i_mem_req_ready), .i_mem_resp(i_mem_resp),
		.i_fetch_rsp(o_fetch_rsp)
	);

	// backing store rule, upper half inverted
	function automatic word_t mem_word(input word_t addr);
		word_t a;
		a = {addr[31:2], 2'b00};
		return {~a[31:16], a[15:0]};
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#10;
	endtask

	task automatic wait_ready;
		while (ready !== 1'b1)
			next_cycle();
	endtask

	// serves one line request with random ready delay and beat spacing
	task automatic serve_line;
		word_t line;
		int gap;
		line = mem_req.addr;
		req_count++;
		last_req_addr = line;
		beats_sent = 0;
		gap = $urandom % 4;
		repeat (gap) next_cycle();
		next_cycle();
		mem_req_ready = 1'b1;
		next_cycle();
		mem_req_ready = 1'b0;
		for (int i = 0; i < WPL; i++) begin
			gap = $urandom % 4;
			repeat (gap) next_cycle();
			mem_resp = '{valid: 1'b1, last: (i == WPL - 1), data: mem_word(line + 4 * i)};
			beats_sent++;
			next_cycle();
			mem_resp.valid = 1'b0;
		end
	endtask

	initial begin
		void'($urandom(32'hcae6));
		forever begin
			@(negedge clk);
			if (mem_req.valid === 1'b1)
				serve_line();
		end
	end

	// flag 1 expects a miss, 0 a hit, 2 a hit whose data is not known
	task automatic run_fetch(input word_t addr, input logic [3:0] flag);
		int reqs_before;
		int crit_seen;
		logic last_prev;
		wait_ready();
		reqs_before = req_count;
		fetch = '{valid: 1'b1, addr: addr};
		next_cycle();
		fetch.valid = 1'b0;
		pa = addr;
		@(negedge clk);
		check_value(stall, flag == 1, $sformatf("miss flag for %h", addr));
		if (!stall) begin
			check_value(fetch_rsp.valid, 1'b1, $sformatf("hit response for %h", addr));
			if (flag == 0)
				check_value(fetch_rsp.data, mem_word(addr), $sformatf("hit data %h", addr));
			@(negedge clk);
			check_value(mem_req.valid, 1'b0, $sformatf("request after hit %h", addr));
			check_value(req_count - reqs_before, 0, $sformatf("requests on hit %h", addr));
		end else begin
			@(negedge clk);
			check_value(mem_req.valid, 1'b1, $sformatf("request after miss %h", addr));
			crit_seen = 0;
			last_prev = 1'b0;
			while (stall) begin
				last_prev = mem_resp.valid && mem_resp.last;
				@(negedge clk);
				if (fetch_rsp.valid) begin
					crit_seen++;
					check_value(fetch_rsp.data, mem_word(addr),
						$sformatf("critical word %h", addr));
				end
			end
			check_value(last_prev, 1'b1, $sformatf("stall drop after last beat %h", addr));
			check_value(crit_seen, 1, $sformatf("critical responses for %h", addr));
			check_value(req_count - reqs_before, 1, $sformatf("requests on miss %h", addr));
			check_value(last_req_addr, {addr[31:5], 5'b0}, "request line address");
			check_value(beats_sent, WPL, "beats before stall dropped");
			// the held fetch goes through again and now hits
			next_cycle();
			fetch = '{valid: 1'b1, addr: addr};
			next_cycle();
			fetch.valid = 1'b0;
			@(negedge clk);
			check_value(stall, 1'b0, $sformatf("stall on refetch %h", addr));
			check_value(fetch_rsp.valid, 1'b1, $sformatf("refetch response %h", addr));
			check_value(fetch_rsp.data, mem_word(addr), $sformatf("refetch data %h", addr));
		end
		next_cycle();
	endtask

	task automatic run_op(input logic [3:0] cmd, input word_t addr);
		wait_ready();
		cop = '{op: cache_op_t'(cmd - 1), addr: addr, tag: addr >> 12};
		next_cycle();
		cop.op = op_none;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: no progress after %0d cycles", cycles);
			$display("test failed");
			$fatal(1);
		end else if (DUT.u_chk.n_errors != 0) begin
			$display("memory or fetch protocol assertion failed");
			$display("test failed");
			$fatal(1);
		end
	end

	initial begin
		int sweep;
		logic [3:0] cmd;
		fetch = '0;
		pa = '0;
		cop = '0;
		mem_req_ready = 1'b0;
		mem_resp = '0;
		$readmemh("bench/icache_stim.txt", stim);
		n_lines = -1;
		for (int i = MAX_LINES - 1; i >= 0; i--) begin
			if (stim[i][39:36] === 4'h0)
				n_lines = i;
		end
		if (n_lines < 0) begin
			$display("stimulus file has no end line");
			$display("test failed");
			$fatal(1);
		end
		cycle_limit = n_lines * 40 + SETS + 40;

		@(negedge clk);
		check_value(ready, 1'b0, "ready during reset");
		check_value(fetch_rsp.valid, 1'b0, "fetch response during reset");
		check_value(mem_req.valid, 1'b0, "memory request during reset");
		wait (!rst);
		sweep = 0;
		while (ready !== 1'b1) begin
			next_cycle();
			sweep++;
		end
		check_value(sweep, SETS, "cycles of invalidation sweep");

		for (int i = 0; i < n_lines; i++) begin
			cmd = stim[i][39:36];
			if (cmd == 4'h1)
				run_fetch(stim[i][35:4], stim[i][3:0]);
			else
				run_op(cmd, stim[i][35:4]);
		end

		next_cycle();
		if (DUT.u_chk.n_errors == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("%0d assertion failures", DUT.u_chk.n_errors);
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

//--- bench/icache_stim.txt
// cmd_address_miss, cmd 1 fetch, 2 index inv, 3 index store tag, 4 hit inv, 0 end
// miss 1 expects a miss, 0 a hit, 2 a hit with unknown data
1_00000000_1
1_00000014_0
1_00001008_1
1_0000201C_1
1_00003004_1
1_00000004_0
1_00004000_1
1_00001000_1
1_00003010_0
1_00002000_1
1_00000000_1
1_00000028_1
1_00000020_0
2_00000020_0
1_00000024_1
4_00003000_0
1_00003000_1
1_0000300C_0
3_00005040_0
1_00005044_2
1_00000048_1
1_00000048_0
1_00010010_1
1_12345678_1
1_12345660_0
0_00000000_0

//--- sim.f
source/icache_bus_pkg.sv
source/icache_ctrl_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_plru.sv
source/icache_refill.sv
source/icache_ctrl.sv
source/icache_top.sv
bench/icache_chk.sv
bench/icache_clk_gen.sv
bench/icache_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = icache_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = test passed

SRCS := $(wildcard source/*.sv bench/*.sv)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
